//--- logic/csamPkg.sv
`default_nettype none

package csamPkg;

        localparam int OperandWidth = 16;
        localparam int FractionBits = 14;
        localparam int ProductWidth = 2 * OperandWidth;

        // the array is registered after this row
        localparam int ArrayCutRow = 8;

        // operand, array and rounder registers
        localparam int Latency = 3;

        typedef logic signed [OperandWidth-1:0] operandT;

        // raw view is written by the final adder
        // field view is what the rounder looks at
        typedef union packed {
                logic signed [ProductWidth-1:0] raw;
                struct packed {
                        logic [ProductWidth-FractionBits-OperandWidth-1:0] overflowBits;
                        logic [OperandWidth-1:0] kept;
                        logic roundBit;
                        logic [FractionBits-2:0] stickyBits;
                } fields;
        } productT;

endpackage

`default_nettype wire

//--- logic/partialProducts.sv
`timescale 1ns/1ps
`default_nettype none

module partialProducts (
        input  csamPkg::operandT x,
        input  csamPkg::operandT y,
        output logic [csamPkg::OperandWidth-1:0][csamPkg::OperandWidth-1:0] ppRows
);

        // row j holds x * y[j], bit i has weight i + j
        // baugh-wooley: a term is complemented when exactly one of its
        // two operand bits is a sign bit, so x[15]*y[15] stays as is
        always_comb begin
                for (int j = 0; j < csamPkg::OperandWidth; j++) begin
                        for (int i = 0; i < csamPkg::OperandWidth; i++) begin
                                ppRows[j][i] = (x[i] & y[j]) ^
                                        ((i == csamPkg::OperandWidth - 1) !=
                                         (j == csamPkg::OperandWidth - 1));
                        end
                end
        end

endmodule

`default_nettype wire

//--- logic/carrySaveRow.sv
`timescale 1ns/1ps
`default_nettype none

module carrySaveRow #(
        parameter bit firstRow = 1'b0
) (
        input  logic [csamPkg::OperandWidth-1:0] ppRow,
        input  logic [csamPkg::OperandWidth-1:0] sumIn,
        input  logic [csamPkg::OperandWidth-1:0] carryIn,
        output logic [csamPkg::OperandWidth-1:0] sumOut,
        output logic [csamPkg::OperandWidth-1:0] carryOut,
        output logic productBit
);

        logic [csamPkg::OperandWidth-1:0] shiftedSum;

        // previous row's sum sits one column further left
        // its bit 0 has already left the array as a product bit
        assign shiftedSum = {1'b0, sumIn[csamPkg::OperandWidth-1:1]};

        generate
                if (firstRow) begin : gHalf
                        // only the sign column gets a carry in, the correction bit
                        assign sumOut = {
                                ppRow[csamPkg::OperandWidth-1] ^ carryIn[csamPkg::OperandWidth-1],
                                ppRow[csamPkg::OperandWidth-2:0] ^ shiftedSum[csamPkg::OperandWidth-2:0]
                        };
                        assign carryOut = {
                                ppRow[csamPkg::OperandWidth-1] & carryIn[csamPkg::OperandWidth-1],
                                ppRow[csamPkg::OperandWidth-2:0] & shiftedSum[csamPkg::OperandWidth-2:0]
                        };
                end else begin : gFull
                        // sign column degenerates to a half adder as shiftedSum is 0 there
                        assign sumOut = ppRow ^ shiftedSum ^ carryIn;
                        assign carryOut = (ppRow & shiftedSum) |
                                          (carryIn & (ppRow ^ shiftedSum));
                end
        endgenerate

        assign productBit = sumOut[0];

endmodule

`default_nettype wire

//--- logic/carrySaveArray.sv
`timescale 1ns/1ps
`default_nettype none

module carrySaveArray (
        input  logic clk,
        input  logic [csamPkg::OperandWidth-1:0][csamPkg::OperandWidth-1:0] ppRows,
        output logic [csamPkg::OperandWidth-1:0] finalSum,
        output logic [csamPkg::OperandWidth-1:0] finalCarry,
        output logic [csamPkg::OperandWidth-1:0] lowBits
);

        logic rowBit [1:csamPkg::OperandWidth-1];

        // state held at the cut
        logic [csamPkg::OperandWidth-1:0] cutSum;
        logic [csamPkg::OperandWidth-1:0] cutCarry;
        logic [csamPkg::ArrayCutRow:0] cutBits;
        logic [csamPkg::OperandWidth-1:csamPkg::ArrayCutRow+1][csamPkg::OperandWidth-1:0] latePp;

        for (genvar r = 1; r < csamPkg::OperandWidth; r++) begin : gRow
                logic [csamPkg::OperandWidth-1:0] sumFeed;
                logic [csamPkg::OperandWidth-1:0] carryFeed;
                logic [csamPkg::OperandWidth-1:0] ppFeed;
                logic [csamPkg::OperandWidth-1:0] sumOut;
                logic [csamPkg::OperandWidth-1:0] carryOut;

                if (r == 1) begin : gFirst
                        // row 0 enters as a plain sum
                        assign sumFeed = ppRows[0];
                        // 2^16 baugh-wooley correction, lands in row 1 at its sign column
                        assign carryFeed = {1'b1, {(csamPkg::OperandWidth-1){1'b0}}};
                end else if (r == csamPkg::ArrayCutRow + 1) begin : gCut
                        assign sumFeed = cutSum;
                        assign carryFeed = cutCarry;
                end else begin : gChain
                        assign sumFeed = gRow[r-1].sumOut;
                        assign carryFeed = gRow[r-1].carryOut;
                end

                if (r > csamPkg::ArrayCutRow) begin : gLatePp
                        assign ppFeed = latePp[r];
                end else begin : gEarlyPp
                        assign ppFeed = ppRows[r];
                end

                carrySaveRow #(
                        .firstRow(r == 1)
                ) row (
                        .ppRow(ppFeed),
                        .sumIn(sumFeed),
                        .carryIn(carryFeed),
                        .sumOut(sumOut),
                        .carryOut(carryOut),
                        .productBit(rowBit[r])
                );
        end

        always_ff @(posedge clk) begin
                cutSum <= gRow[csamPkg::ArrayCutRow].sumOut;
                cutCarry <= gRow[csamPkg::ArrayCutRow].carryOut;
                cutBits[0] <= ppRows[0][0];
                for (int r = 1; r <= csamPkg::ArrayCutRow; r++) begin
                        cutBits[r] <= rowBit[r];
                end
                for (int r = csamPkg::ArrayCutRow + 1; r < csamPkg::OperandWidth; r++) begin
                        latePp[r] <= ppRows[r];
                end
        end

        // bits up to the cut come out of the register, the rest are fresh
        for (genvar i = 0; i < csamPkg::OperandWidth; i++) begin : gLow
                if (i <= csamPkg::ArrayCutRow) begin : gEarly
                        assign lowBits[i] = cutBits[i];
                end else begin : gLate
                        assign lowBits[i] = rowBit[i];
                end
        end

        assign finalSum = gRow[csamPkg::OperandWidth-1].sumOut;
        assign finalCarry = gRow[csamPkg::OperandWidth-1].carryOut;

endmodule

`default_nettype wire

//--- logic/carryPropagateAdder.sv
`timescale 1ns/1ps
`default_nettype none

module carryPropagateAdder (
        input  logic [csamPkg::OperandWidth-1:0] finalSum,
        input  logic [csamPkg::OperandWidth-1:0] finalCarry,
        input  logic [csamPkg::OperandWidth-1:0] lowBits,
        output csamPkg::productT product
);

        logic [csamPkg::OperandWidth-2:0] upper;
        logic [csamPkg::OperandWidth-2:0] ripple;
        logic topBit;

        // sum bit k+1 and carry bit k share weight 16 + k
        always_comb begin
                upper[0] = finalSum[1] ^ finalCarry[0];
                ripple[0] = finalSum[1] & finalCarry[0];
                for (int k = 1; k < csamPkg::OperandWidth - 1; k++) begin
                        upper[k] = finalSum[k+1] ^ finalCarry[k] ^ ripple[k-1];
                        ripple[k] = (finalSum[k+1] & finalCarry[k]) |
                                    (ripple[k-1] & (finalSum[k+1] ^ finalCarry[k]));
                end
        end

        // bit 31 also absorbs the 2^31 correction term, so it is inverted
        assign topBit = ~(finalCarry[csamPkg::OperandWidth-1] ^ ripple[csamPkg::OperandWidth-2]);

        assign product.raw = {topBit, upper, lowBits};

endmodule

`default_nettype wire

//--- logic/roundNearestEven.sv
`timescale 1ns/1ps
`default_nettype none

module roundNearestEven (
        input  logic clk,
        input  csamPkg::productT product,
        output csamPkg::operandT rounded
);

        logic sticky;
        logic roundUp;
        csamPkg::operandT nextRounded;

        assign sticky = |product.fields.stickyBits;

        // above half, or exactly half with an odd kept value
        assign roundUp = product.fields.roundBit & (sticky | product.fields.kept[0]);

        // no saturation, the top of the range wraps
        assign nextRounded = product.fields.kept + csamPkg::OperandWidth'(roundUp);

        always_ff @(posedge clk) begin
                rounded <= nextRounded;
        end

endmodule

`default_nettype wire

//--- logic/csam.sv
`timescale 1ns/1ps
`default_nettype none

module csam (
        input  logic clk,
        input  logic rst,
        input  csamPkg::operandT x,
        input  csamPkg::operandT y,
        input  logic inValid,
        output csamPkg::operandT rounded,
        output logic outValid
);

        csamPkg::operandT xReg;
        csamPkg::operandT yReg;
        logic [csamPkg::Latency-1:0] validPipe;
        logic [csamPkg::OperandWidth-1:0][csamPkg::OperandWidth-1:0] ppRows;
        logic [csamPkg::OperandWidth-1:0] finalSum;
        logic [csamPkg::OperandWidth-1:0] finalCarry;
        logic [csamPkg::OperandWidth-1:0] lowBits;
        csamPkg::productT product;

        always_ff @(posedge clk) begin
                xReg <= x;
                yReg <= y;
        end

        // one valid bit per stage: operands, array cut, rounder
        always_ff @(posedge clk) begin
                if (rst) begin
                        validPipe <= '0;
                end else begin
                        validPipe <= {validPipe[csamPkg::Latency-2:0], inValid};
                end
        end

        assign outValid = validPipe[csamPkg::Latency-1];

        partialProducts ppGen (
                .x(xReg),
                .y(yReg),
                .ppRows(ppRows)
        );

        carrySaveArray csArray (
                .clk(clk),
                .ppRows(ppRows),
                .finalSum(finalSum),
                .finalCarry(finalCarry),
                .lowBits(lowBits)
        );

        carryPropagateAdder cpa (
                .finalSum(finalSum),
                .finalCarry(finalCarry),
                .lowBits(lowBits),
                .product(product)
        );

        roundNearestEven rounder (
                .clk(clk),
                .product(product),
                .rounded(rounded)
        );

endmodule

`default_nettype wire

//--- test/csam_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csamChecker (
        input logic clk,
        input logic rst,
        input logic inValid,
        input logic outValid,
        input csamPkg::operandT rounded
);

        // history before the first reset means nothing
        logic resetSeen = 1'b0;

        always @(posedge clk) begin
                if (rst) begin
                        resetSeen <= 1'b1;
                end
        end

        // strobe passes through operand, cut and rounder registers
        validFollowsInput: assert property (@(posedge clk)
                resetSeen && !$past(rst) && !$past(rst, 2) && !$past(rst, 3) |->
                outValid == $past(inValid, 3))
                else $error("outValid does not follow inValid by three cycles");

        // the whole valid pipe is cleared, so nothing leaks out for two more edges
        quietAfterReset: assert property (@(posedge clk)
                $past(rst) || $past(rst, 2) |-> !outValid)
                else $error("outValid high during or right after reset");

        knownResult: assert property (@(posedge clk)
                outValid |-> !$isunknown(rounded))
                else $error("rounded has unknown bits while outValid is high");

endmodule

bind csam csamChecker timingCheck (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .outValid(outValid),
        .rounded(rounded)
);

`default_nettype wire

//--- test/csamTb.sv
`timescale 1ns/1ps
`default_nettype none

module csamTb;

        localparam int TimeoutCycles = 4000;
        localparam int StreamPairs = 500;

        logic clk;
        logic rst;
        csamPkg::operandT x;
        csamPkg::operandT y;
        logic inValid;
        csamPkg::operandT rounded;
        logic outValid;

        // expected results, and the falling edge at which each must show up
        csamPkg::operandT expectQ [$];
        int dueQ [$];
        int cycle;
        int ticks = 0;

        csam DUT (
                .clk(clk),
                .rst(rst),
                .x(x),
                .y(y),
                .inValid(inValid),
                .rounded(rounded),
                .outValid(outValid)
        );

        initial begin
                clk = 1'b0;
        end

        always #50 clk = ~clk;

        always @(posedge clk) begin
                ticks <= ticks + 1;
                if (ticks >= TimeoutCycles) begin
                        failRun("timeout, the run went past its cycle limit");
                end
        end

        task automatic failRun(input string what);
                $display("%s", what);
                $display("TEST FAIL");
                $fatal(1, "stopping at the first error");
        endtask

        task automatic compareRounded(input string name, input csamPkg::operandT got,
                        input csamPkg::operandT expected);
                if (got !== expected) begin
                        $display("** Error: %s is 0x%04h, expected 0x%04h", name, got, expected);
                        failRun("rounded value mismatch");
                end
        endtask

        // Q4.28 product, then keep bits 29..14 and round on 13 and below
        function automatic csamPkg::operandT expectedRound(input csamPkg::operandT a,
                        input csamPkg::operandT b);
                csamPkg::productT p;
                logic sticky;
                p.raw = a * b;
                sticky = |p.fields.stickyBits;
                if (p.fields.roundBit && (sticky || p.fields.kept[0])) begin
                        return p.fields.kept + 16'd1;
                end else begin
                        return p.fields.kept;
                end
        endfunction

        function automatic csamPkg::operandT randomOperand();
                return csamPkg::operandT'($urandom());
        endfunction

        task automatic checkOutputs();
                if (outValid) begin
                        if (dueQ.size() == 0) begin
                                failRun("outValid went high with no result pending");
                        end else if (dueQ[0] != cycle) begin
                                failRun("outValid came at the wrong cycle");
                        end else begin
                                compareRounded("rounded", rounded, expectQ.pop_front());
                                void'(dueQ.pop_front());
                        end
                end else if (dueQ.size() != 0 && dueQ[0] <= cycle) begin
                        failRun("outValid stayed low when a result was due");
                end
        endtask

        // one falling edge: check what came out, then drive the next inputs
        task automatic stepCycle(input logic resetIn, input logic validIn,
                        input csamPkg::operandT a, input csamPkg::operandT b,
                        input csamPkg::operandT expected);
                @(negedge clk);
                cycle++;
                checkOutputs();
                rst = resetIn;
                inValid = validIn;
                x = a;
                y = b;
                if (resetIn) begin
                        expectQ.delete();
                        dueQ.delete();
                end else if (validIn) begin
                        expectQ.push_back(expected);
                        dueQ.push_back(cycle + csamPkg::Latency);
                end
        endtask

        task automatic sendPair(input csamPkg::operandT a, input csamPkg::operandT b,
                        input csamPkg::operandT expected);
                compareRounded("reference model", expectedRound(a, b), expected);
                stepCycle(1'b0, 1'b1, a, b, expected);
        endtask

        task automatic sendModeled(input csamPkg::operandT a, input csamPkg::operandT b);
                stepCycle(1'b0, 1'b1, a, b, expectedRound(a, b));
        endtask

        task automatic drainResults();
                while (dueQ.size() != 0) begin
                        stepCycle(1'b0, 1'b0, '0, '0, '0);
                end
                stepCycle(1'b0, 1'b0, '0, '0, '0);
        endtask

        task automatic testExact();
                sendPair(16'sh4000, 16'sh6000, 16'sh6000);
                sendPair(16'sh0000, 16'sh7abc, 16'sh0000);
                sendPair(16'sh5a5a, 16'sh0000, 16'sh0000);
                sendPair(16'shc000, 16'sh2000, 16'she000);
                sendPair(16'sh4000, 16'sh4000, 16'sh4000);
                sendPair(16'sh4000, 16'sh9234, 16'sh9234);
                drainResults();
        endtask

        task automatic testTies();
                // exactly half an LSB, goes to the even neighbour
                sendPair(16'sh0001, 16'sh2000, 16'sh0000);
                sendPair(16'sh0003, 16'sh2000, 16'sh0002);
                sendPair(16'sh0005, 16'sh2000, 16'sh0002);
                sendPair(16'sh4001, 16'sh2000, 16'sh2000);
                sendPair(16'sh4003, 16'sh2000, 16'sh2002);
                sendPair(16'shfffd, 16'sh2000, 16'shfffe);
                sendPair(16'shffff, 16'sh2000, 16'sh0000);
                drainResults();
        endtask

        task automatic testOffTie();
                sendPair(16'sh0001, 16'sh2001, 16'sh0001);
                sendPair(16'sh0001, 16'sh1fff, 16'sh0000);
                sendPair(16'sh0003, 16'sh1fff, 16'sh0001);
                sendPair(16'sh0005, 16'sh2001, 16'sh0003);
                sendPair(16'shffff, 16'sh2001, 16'shffff);
                sendPair(16'shffff, 16'sh1fff, 16'sh0000);
                drainResults();
        endtask

        task automatic testSignsExtremes();
                // -2.0 squared is 4.0, which wraps to zero
                sendPair(16'sh8000, 16'sh8000, 16'sh0000);
                sendPair(16'sh8000, 16'sh7fff, 16'sh0002);
                sendPair(16'sh7fff, 16'sh8000, 16'sh0002);
                sendPair(16'sh7fff, 16'sh7fff, 16'shfffc);
                sendPair(16'shc000, 16'shc000, 16'sh4000);
                sendPair(16'sh8000, 16'sh4000, 16'sh8000);
                sendPair(16'sh8000, 16'shc000, 16'sh8000);
                sendPair(16'sh8000, 16'sh0001, 16'shfffe);
                sendPair(16'sh8000, 16'shffff, 16'sh0002);
                sendPair(16'shffff, 16'shffff, 16'sh0000);
                drainResults();
        endtask

        task automatic testStream();
                for (int n = 0; n < StreamPairs; n++) begin
                        sendModeled(randomOperand(), randomOperand());
                end
                drainResults();
        endtask

        task automatic testResetMidStream();
                for (int n = 0; n < 20; n++) begin
                        sendModeled(randomOperand(), randomOperand());
                end
                // one pair leaves as reset goes in, the two behind it must vanish
                for (int n = 0; n < 4; n++) begin
                        stepCycle(1'b1, 1'b1, randomOperand(), randomOperand(), '0);
                end
                for (int n = 0; n < 20; n++) begin
                        sendModeled(randomOperand(), randomOperand());
                end
                drainResults();
        endtask

        initial begin
                rst = 1'b1;
                inValid = 1'b0;
                x = '0;
                y = '0;
                cycle = 0;
                void'($urandom(32'h6ee9_3b54));

                // rst is already high at the first rising edge
                repeat (9) begin
                        stepCycle(1'b1, 1'b0, '0, '0, '0);
                end

                testExact();
                testTies();
                testOffTie();
                testSignsExtremes();
                testStream();
                testResetMidStream();

                $display("TEST PASS");
                $finish;
        end

endmodule

`default_nettype wire

//--- sources.f
logic/csamPkg.sv
logic/partialProducts.sv
logic/carrySaveRow.sv
logic/carrySaveArray.sv
logic/carryPropagateAdder.sv
logic/roundNearestEven.sv
logic/csam.sv
test/csam_checker.sv
test/csamTb.sv

//--- run.sh
#!/bin/sh
# Builds the csam testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
        --top-module csamTb \
        -Mdir obj_dir \
        -o csamSim \
        -f sources.f
status=$?
if [ $status -ne 0 ]; then
        echo "verilator build failed with status $status"
        exit 1
fi

./obj_dir/csamSim
status=$?
if [ $status -ne 0 ]; then
        echo "simulation failed with status $status"
        exit 1
fi

exit 0
